//--- design/gpio_bank.sv
//**************************************************************************
// GPIO register bank with byte-lane writes
// Pins pass a two-flop synchronizer; rising edges set status bits,
// status is write-one-to-clear and a new edge wins over a clear
// Bank identity comes from p_width, so the bank widths must differ
//**************************************************************************
`default_nettype none

`include "wb_io_settings.svh"

module gpio_bank import wb_io_pkg::*; #(
   parameter int p_width = 32
) (
   input  wire                i_clk,
   input  wire                i_rst,
   io_req_if.bank             req,
   input  wire  [p_width-1:0] i_pins,
   output logic [p_width-1:0] o_pins,
   output logic [p_width-1:0] o_oe,
   output word_t              o_rdata,
   output logic               o_irq
);

   localparam bank_e l_bank = (p_width == `GPIO_WIDTH) ? BANK_GPIO : BANK_BTN;

   logic [p_width-1:0] sync_m;
   logic [p_width-1:0] sync_q;
   logic [p_width-1:0] sync_d;
   logic [p_width-1:0] data_out;
   logic [p_width-1:0] out_en;
   logic [p_width-1:0] irq_en;
   logic [p_width-1:0] irq_status;
   logic [p_width-1:0] rise;
   logic [p_width-1:0] wmask;
   logic [p_width-1:0] wbits;
   logic [p_width-1:0] clr;
   word_t              lane_mask;
   logic               wr_hit;

   always_comb begin
      lane_mask = '0;
      for (int b = 0; b < `WB_IO_SEL_W; b++) begin
         lane_mask[8*b +: 8] = {8{req.sel[b]}};
      end
   end

   assign wr_hit = req.valid && req.we && (req.bank_id == l_bank);
   assign wmask  = lane_mask[p_width-1:0];
   assign wbits  = req.wdat[p_width-1:0];
   assign rise   = sync_q & ~sync_d;
   assign clr    = (wr_hit && req.reg_idx == REG_IRQ_STATUS) ? (wbits & wmask) : '0;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         sync_m     <= '0;
         sync_q     <= '0;
         sync_d     <= '0;
         data_out   <= '0;
         out_en     <= '0;
         irq_en     <= '0;
         irq_status <= '0;
      end else begin
         sync_m     <= i_pins;
         sync_q     <= sync_m;
         sync_d     <= sync_q;
         irq_status <= (irq_status & ~clr) | rise;
         if (wr_hit) begin
            case (req.reg_idx)
               REG_DATA_OUT: data_out <= (data_out & ~wmask) | (wbits & wmask);
               REG_OE:       out_en   <= (out_en & ~wmask) | (wbits & wmask);
               REG_IRQ_EN:   irq_en   <= (irq_en & ~wmask) | (wbits & wmask);
               default:      ;
            endcase
         end
      end
   end

   //**************************************************************************
   // Outputs
   //**************************************************************************
   assign o_pins = data_out;
   assign o_oe   = out_en;
   // OR of registered bits, registered again in the response stage
   assign o_irq  = |(irq_status & irq_en);

   always_comb begin
      case (req.reg_idx)
         REG_DATA_IN:    o_rdata = word_t'(sync_q);
         REG_DATA_OUT:   o_rdata = word_t'(data_out);
         REG_OE:         o_rdata = word_t'(out_en);
         REG_IRQ_EN:     o_rdata = word_t'(irq_en);
         REG_IRQ_STATUS: o_rdata = word_t'(irq_status);
         default:        o_rdata = '0;
      endcase
   end

   generate
      if (p_width < `WB_IO_DAT_W) begin : g_narrow
         a_status_in_range: assert property (
            @(posedge i_clk) disable iff (i_rst)
            (req.reg_idx == REG_IRQ_STATUS) |-> (o_rdata[`WB_IO_DAT_W-1:p_width] == '0)
         );
      end
   endgenerate

endmodule

`default_nettype wire

//--- design/wb_io_decode.sv
//**************************************************************************
// Wishbone request register and address decoder
// Pipelined Wishbone without stall, one request per strobe cycle
// Address bit 5 inside a bank, or any address outside both banks,
// decodes to BANK_NONE
//**************************************************************************
`default_nettype none

`include "wb_io_settings.svh"

module wb_io_decode import wb_io_pkg::*; (
   input  wire                     i_clk,
   input  wire                     i_rst,
   input  wire                     i_wb_cyc,
   input  wire                     i_wb_stb,
   input  wire                     i_wb_we,
   input  wire [`WB_IO_ADR_W-1:0]  i_wb_adr,
   input  wire [`WB_IO_DAT_W-1:0]  i_wb_dat,
   input  wire [`WB_IO_SEL_W-1:0]  i_wb_sel,
   io_req_if.decode                req
);

   localparam logic [`WB_IO_ADR_W-1:0] l_gpio_base = `GPIO_BASE;
   localparam logic [`WB_IO_ADR_W-1:0] l_btn_base  = `BTN_BASE;

   bank_e bank_d;

   // Upper bits pick the bank, top bit of the span must be clear
   always_comb begin
      bank_d = BANK_NONE;
      if (!i_wb_adr[`BANK_SPAN_BITS-1]) begin
         if (i_wb_adr[`WB_IO_ADR_W-1:`BANK_SPAN_BITS] ==
             l_gpio_base[`WB_IO_ADR_W-1:`BANK_SPAN_BITS]) begin
            bank_d = BANK_GPIO;
         end else if (i_wb_adr[`WB_IO_ADR_W-1:`BANK_SPAN_BITS] ==
                      l_btn_base[`WB_IO_ADR_W-1:`BANK_SPAN_BITS]) begin
            bank_d = BANK_BTN;
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         req.valid <= 1'b0;
      end else begin
         req.valid <= i_wb_cyc && i_wb_stb;
      end
   end

   // Payload
   always_ff @(posedge i_clk) begin
      req.bank_id <= bank_d;
      req.reg_idx <= reg_e'(i_wb_adr[4:2]);
      req.we      <= i_wb_we;
      req.wdat    <= i_wb_dat;
      req.sel     <= i_wb_sel;
   end

   a_no_valid_after_rst: assert property (
      @(posedge i_clk) $past(i_rst) |-> !req.valid
   );

endmodule

`default_nettype wire

//--- design/wb_io_if.sv
//**************************************************************************
// Decoded request from the address decoder to the banks and the
// response stage
// Valid for one cycle per request, payload only meaningful with valid
//**************************************************************************
`default_nettype none

`include "wb_io_settings.svh"

interface io_req_if import wb_io_pkg::*; ();

   logic                    valid;
   bank_e                   bank_id;
   reg_e                    reg_idx;
   logic                    we;
   word_t                   wdat;
   logic [`WB_IO_SEL_W-1:0] sel;

   modport decode (
      output valid,
      output bank_id,
      output reg_idx,
      output we,
      output wdat,
      output sel
   );

   // Both GPIO banks
   modport bank (
      input valid,
      input bank_id,
      input reg_idx,
      input we,
      input wdat,
      input sel
   );

   modport result (
      input valid,
      input bank_id,
      input we
   );

endinterface

`default_nettype wire

//--- design/wb_io_pkg.sv
//**************************************************************************
// Shared types of the Wishbone GPIO subsystem
// Register indices 5 to 7 are reserved and read as zero
//**************************************************************************
`default_nettype none

`include "wb_io_settings.svh"

package wb_io_pkg;

   // Target of a decoded request
   typedef enum logic [1:0] {
      BANK_GPIO = 2'd0,
      BANK_BTN  = 2'd1,
      BANK_NONE = 2'd2
   } bank_e;

   // Register index inside a bank, address bits 4 to 2
   typedef enum logic [2:0] {
      REG_DATA_IN    = 3'd0,
      REG_DATA_OUT   = 3'd1,
      REG_OE         = 3'd2,
      REG_IRQ_EN     = 3'd3,
      REG_IRQ_STATUS = 3'd4
   } reg_e;

   typedef logic [`WB_IO_DAT_W-1:0] word_t;

endpackage

`default_nettype wire

//--- design/wb_io_result.sv
//**************************************************************************
// Response stage: read data, ack or err, and the combined interrupt
// Fixed two-cycle latency from request to response, no stall
// Write responses carry zero data
//**************************************************************************
`default_nettype none

`include "wb_io_settings.svh"

module wb_io_result import wb_io_pkg::*; (
   input  wire                     i_clk,
   input  wire                     i_rst,
   io_req_if.result                req,
   input  word_t                   i_gpio_rdata,
   input  word_t                   i_btn_rdata,
   input  wire                     i_gpio_irq,
   input  wire                     i_btn_irq,
   output logic [`WB_IO_DAT_W-1:0] o_wb_rdt,
   output logic                    o_wb_ack,
   output logic                    o_wb_err,
   output logic                    o_irq
);

   word_t rdata_d;

   always_comb begin
      rdata_d = '0;
      if (!req.we) begin
         case (req.bank_id)
            BANK_GPIO: rdata_d = i_gpio_rdata;
            BANK_BTN:  rdata_d = i_btn_rdata;
            default:   rdata_d = '0;
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_wb_ack <= 1'b0;
         o_wb_err <= 1'b0;
         o_wb_rdt <= '0;
         o_irq    <= 1'b0;
      end else begin
         o_wb_ack <= req.valid && (req.bank_id != BANK_NONE);
         o_wb_err <= req.valid && (req.bank_id == BANK_NONE);
         o_wb_rdt <= rdata_d;
         o_irq    <= i_gpio_irq || i_btn_irq;
      end
   end

   a_ack_err_excl: assert property (
      @(posedge i_clk) disable iff (i_rst)
      !(o_wb_ack && o_wb_err)
   );

endmodule

`default_nettype wire

//--- design/wb_io_settings.svh
//**************************************************************************
// Widths and address map of the Wishbone GPIO subsystem
// The two banks need different pin counts; a bank tells itself
// apart from the other one by its width
// Bank bases must be aligned to the bank span
//**************************************************************************
`ifndef WB_IO_SETTINGS_SVH
`define WB_IO_SETTINGS_SVH

// Bus widths
`define WB_IO_ADR_W    16
`define WB_IO_DAT_W    32
`define WB_IO_SEL_W    (`WB_IO_DAT_W / 8)

// Pin counts per bank
`define GPIO_WIDTH     32
`define BTN_WIDTH      5

// Address map, byte addresses
`define GPIO_BASE      16'h0000
`define BTN_BASE       16'h0040
`define BANK_SPAN_BITS 6

`endif

//--- design/wb_io_top.sv
//**************************************************************************
// Wishbone GPIO subsystem top level
// LED/switch bank and button bank behind one pipelined Wishbone port
// Pins are split into input, output and output enable; the pad cells
// belong to the board top level
//**************************************************************************
`default_nettype none

`include "wb_io_settings.svh"

module wb_io_top import wb_io_pkg::*; (
   input  wire                     i_clk,
   input  wire                     i_rst,
   // Wishbone request
   input  wire                     i_wb_cyc,
   input  wire                     i_wb_stb,
   input  wire                     i_wb_we,
   input  wire [`WB_IO_ADR_W-1:0]  i_wb_adr,
   input  wire [`WB_IO_DAT_W-1:0]  i_wb_dat,
   input  wire [`WB_IO_SEL_W-1:0]  i_wb_sel,
   // Wishbone response
   output wire [`WB_IO_DAT_W-1:0]  o_wb_rdt,
   output wire                     o_wb_ack,
   output wire                     o_wb_err,
   // Pins
   input  wire [`GPIO_WIDTH-1:0]   i_gpio,
   output wire [`GPIO_WIDTH-1:0]   o_gpio,
   output wire [`GPIO_WIDTH-1:0]   o_gpio_oe,
   input  wire [`BTN_WIDTH-1:0]    i_btn,
   output wire [`BTN_WIDTH-1:0]    o_btn,
   output wire [`BTN_WIDTH-1:0]    o_btn_oe,
   output wire                     o_irq
);

   io_req_if req ();

   word_t gpio_rdata;
   word_t btn_rdata;
   logic  gpio_irq;
   logic  btn_irq;

   wb_io_decode u_decode (
      .i_clk    (i_clk),
      .i_rst    (i_rst),
      .i_wb_cyc (i_wb_cyc),
      .i_wb_stb (i_wb_stb),
      .i_wb_we  (i_wb_we),
      .i_wb_adr (i_wb_adr),
      .i_wb_dat (i_wb_dat),
      .i_wb_sel (i_wb_sel),
      .req      (req.decode)
   );

   // LEDs and switches
   gpio_bank #(.p_width(`GPIO_WIDTH)) u_gpio (
      .i_clk   (i_clk),
      .i_rst   (i_rst),
      .req     (req.bank),
      .i_pins  (i_gpio),
      .o_pins  (o_gpio),
      .o_oe    (o_gpio_oe),
      .o_rdata (gpio_rdata),
      .o_irq   (gpio_irq)
   );

   // Push buttons
   gpio_bank #(.p_width(`BTN_WIDTH)) u_btn (
      .i_clk   (i_clk),
      .i_rst   (i_rst),
      .req     (req.bank),
      .i_pins  (i_btn),
      .o_pins  (o_btn),
      .o_oe    (o_btn_oe),
      .o_rdata (btn_rdata),
      .o_irq   (btn_irq)
   );

   wb_io_result u_result (
      .i_clk        (i_clk),
      .i_rst        (i_rst),
      .req          (req.result),
      .i_gpio_rdata (gpio_rdata),
      .i_btn_rdata  (btn_rdata),
      .i_gpio_irq   (gpio_irq),
      .i_btn_irq    (btn_irq),
      .o_wb_rdt     (o_wb_rdt),
      .o_wb_ack     (o_wb_ack),
      .o_wb_err     (o_wb_err),
      .o_irq        (o_irq)
   );

endmodule

`default_nettype wire

//--- files.f
+incdir+design
design/wb_io_pkg.sv
design/wb_io_if.sv
design/wb_io_decode.sv
design/gpio_bank.sv
design/wb_io_result.sv
design/wb_io_top.sv
tests/tb_checker.sv
tests/tb_top.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it into sim.log and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --timescale 1ns/1ps -f files.f \
   --top-module tb_top -Mdir obj_dir -o tb_top_sim > build.log 2>&1 \
   || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/tb_top_sim > sim.log 2>&1
grep -qx "NO ERRORS" sim.log && echo "Simulation passed" \
   || { tail -n 20 sim.log; echo "Simulation failed, see sim.log"; exit 1; }

//--- tests/tb_checker.sv
//**************************************************************************
// Response and pin checker for the Wishbone GPIO subsystem
// Expects one response per sampled strobe, one edge after sampling
// Pins and o_irq are only compared when the idle check input is high
//**************************************************************************
`default_nettype none

`include "wb_io_settings.svh"

module tb_checker (
   input  wire                    i_clk,
   input  wire                    i_rst,
   input  wire                    i_wb_cyc,
   input  wire                    i_wb_stb,
   input  wire [`WB_IO_DAT_W-1:0] i_wb_rdt,
   input  wire                    i_wb_ack,
   input  wire                    i_wb_err,
   input  wire [`GPIO_WIDTH-1:0]  i_gpio,
   input  wire [`GPIO_WIDTH-1:0]  i_gpio_oe,
   input  wire [`BTN_WIDTH-1:0]   i_btn,
   input  wire [`BTN_WIDTH-1:0]   i_btn_oe,
   input  wire                    i_irq,
   // Expected response of the request on the bus
   input  wire                    i_exp_err,
   input  wire [`WB_IO_DAT_W-1:0] i_exp_rdata,
   // Expected pin and interrupt state at the end of an idle gap
   input  wire                    i_idle_chk,
   input  wire [`GPIO_WIDTH-1:0]  i_exp_gpio,
   input  wire [`GPIO_WIDTH-1:0]  i_exp_gpio_oe,
   input  wire [`BTN_WIDTH-1:0]   i_exp_btn,
   input  wire [`BTN_WIDTH-1:0]   i_exp_btn_oe,
   input  wire                    i_exp_irq,
   output int                     o_chk_cnt,
   output int                     o_val_errs,
   output int                     o_proto_errs,
   output int                     o_pending
);
   timeunit 1ns;
   timeprecision 1ps;

   typedef struct packed {
      logic        err;
      logic [31:0] rdata;
      logic [31:0] due;
   } resp_t;

   resp_t       resp_q[$];
   resp_t       entry;
   resp_t       head;
   logic [31:0] edge_cnt = '0;

   task automatic check_value(input string what, input logic [31:0] exp,
                              input logic [31:0] got);
      o_chk_cnt++;
      if (got !== exp) begin
         o_val_errs++;
         $display("** Error at %0d ns: %s expected %h, got %h", $time, what, exp, got);
      end
   endtask

   task automatic protocol_error(input string msg);
      o_proto_errs++;
      $display("Protocol failure at %0d ns: %s", $time, msg);
   endtask

   // Queue the expected response, due one edge after the sampling edge
   always @(posedge i_clk) begin
      if (!i_rst && i_wb_cyc && i_wb_stb) begin
         entry.err   = i_exp_err;
         entry.rdata = i_exp_rdata;
         entry.due   = edge_cnt + 32'd2;
         resp_q.push_back(entry);
      end
      edge_cnt <= edge_cnt + 32'd1;
   end

   //**************************************************************************
   // Compare at the falling edge, away from DUT updates
   //**************************************************************************
   always @(negedge i_clk) begin
      if (!i_rst) begin
         if (i_wb_ack && i_wb_err) begin
            protocol_error("ack and err were high in the same cycle");
         end
         if (i_wb_ack || i_wb_err) begin
            if (resp_q.size() == 0) begin
               protocol_error("a response arrived with no request outstanding");
            end else begin
               head = resp_q.pop_front();
               if (head.due != edge_cnt) begin
                  protocol_error("a response did not arrive two cycles after its request");
               end
               check_value("err flag", 32'(head.err), 32'(i_wb_err));
               if (!head.err && i_wb_ack) begin
                  check_value("read data", head.rdata, i_wb_rdt);
               end
            end
         end else if (resp_q.size() != 0 && resp_q[0].due < edge_cnt) begin
            void'(resp_q.pop_front());
            protocol_error("a request never got a response");
         end
         if (i_idle_chk) begin
            check_value("o_gpio", i_exp_gpio, i_gpio);
            check_value("o_gpio_oe", i_exp_gpio_oe, i_gpio_oe);
            check_value("o_btn", 32'(i_exp_btn), 32'(i_btn));
            check_value("o_btn_oe", 32'(i_exp_btn_oe), 32'(i_btn_oe));
            check_value("o_irq", 32'(i_exp_irq), 32'(i_irq));
         end
         o_pending = resp_q.size();
      end
   end

endmodule

`default_nettype wire

//--- tests/tb_top.sv
//**************************************************************************
// Testbench for the Wishbone GPIO subsystem
// Random requests from a Galois LFSR with seed 95, predicted by a
// register and pin model; pins only change in idle gaps of 8 cycles
// Assumes the LED/switch bank is a full 32 bits wide
//**************************************************************************
`default_nettype none

`include "wb_io_settings.svh"

module tb_top;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int          l_clk_period = 100;
   localparam int          l_drv_dly    = 10;
   localparam int          l_rst_cycles = 4;
   localparam int          l_num_req    = 600;
   localparam int          l_batch      = 20;
   localparam int          l_gap        = 8;
   localparam int          l_num_gaps   = l_num_req / l_batch + 1;
   // At most two cycles per request, plus gaps, reset and drain
   localparam int          l_max_cycles = 2 * l_num_req + l_num_gaps * l_gap
                                          + l_rst_cycles + 20;
   localparam logic [31:0] l_lfsr_taps  = 32'hB4BC_D35C;
   localparam int          l_none       = 2;
   localparam logic [`WB_IO_ADR_W-1:0] l_gpio_base = `GPIO_BASE;
   localparam logic [`WB_IO_ADR_W-1:0] l_btn_base  = `BTN_BASE;

   logic                    clk;
   logic                    rst;
   logic                    wb_cyc;
   logic                    wb_stb;
   logic                    wb_we;
   logic [`WB_IO_ADR_W-1:0] wb_adr;
   logic [`WB_IO_DAT_W-1:0] wb_dat;
   logic [`WB_IO_SEL_W-1:0] wb_sel;
   wire  [`WB_IO_DAT_W-1:0] wb_rdt;
   wire                     wb_ack;
   wire                     wb_err;
   logic [`GPIO_WIDTH-1:0]  gpio_in;
   wire  [`GPIO_WIDTH-1:0]  gpio_out;
   wire  [`GPIO_WIDTH-1:0]  gpio_oe;
   logic [`BTN_WIDTH-1:0]   btn_in;
   wire  [`BTN_WIDTH-1:0]   btn_out;
   wire  [`BTN_WIDTH-1:0]   btn_oe;
   wire                     irq;

   logic                    exp_err;
   logic [`WB_IO_DAT_W-1:0] exp_rdata;
   logic                    idle_chk;
   logic [`GPIO_WIDTH-1:0]  exp_gpio;
   logic [`GPIO_WIDTH-1:0]  exp_gpio_oe;
   logic [`BTN_WIDTH-1:0]   exp_btn;
   logic [`BTN_WIDTH-1:0]   exp_btn_oe;
   logic                    exp_irq;
   int                      chk_cnt;
   int                      val_errs;
   int                      proto_errs;
   int                      pending;
   logic [31:0]             lfsr;

   // Model state per bank, index 0 is GPIO and 1 is buttons
   logic [31:0] m_in  [2];
   logic [31:0] m_out [2];
   logic [31:0] m_oe  [2];
   logic [31:0] m_en  [2];
   logic [31:0] m_st  [2];

   wb_io_top wb_io_top_i (
      .i_clk     (clk),
      .i_rst     (rst),
      .i_wb_cyc  (wb_cyc),
      .i_wb_stb  (wb_stb),
      .i_wb_we   (wb_we),
      .i_wb_adr  (wb_adr),
      .i_wb_dat  (wb_dat),
      .i_wb_sel  (wb_sel),
      .o_wb_rdt  (wb_rdt),
      .o_wb_ack  (wb_ack),
      .o_wb_err  (wb_err),
      .i_gpio    (gpio_in),
      .o_gpio    (gpio_out),
      .o_gpio_oe (gpio_oe),
      .i_btn     (btn_in),
      .o_btn     (btn_out),
      .o_btn_oe  (btn_oe),
      .o_irq     (irq)
   );

   tb_checker u_checker (
      .i_clk         (clk),
      .i_rst         (rst),
      .i_wb_cyc      (wb_cyc),
      .i_wb_stb      (wb_stb),
      .i_wb_rdt      (wb_rdt),
      .i_wb_ack      (wb_ack),
      .i_wb_err      (wb_err),
      .i_gpio        (gpio_out),
      .i_gpio_oe     (gpio_oe),
      .i_btn         (btn_out),
      .i_btn_oe      (btn_oe),
      .i_irq         (irq),
      .i_exp_err     (exp_err),
      .i_exp_rdata   (exp_rdata),
      .i_idle_chk    (idle_chk),
      .i_exp_gpio    (exp_gpio),
      .i_exp_gpio_oe (exp_gpio_oe),
      .i_exp_btn     (exp_btn),
      .i_exp_btn_oe  (exp_btn_oe),
      .i_exp_irq     (exp_irq),
      .o_chk_cnt     (chk_cnt),
      .o_val_errs    (val_errs),
      .o_proto_errs  (proto_errs),
      .o_pending     (pending)
   );

   initial begin
      clk = 1'b0;
      forever #(l_clk_period / 2) clk = ~clk;
   end

   //**************************************************************************
   // Random source and model
   //**************************************************************************
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ l_lfsr_taps) : (s >> 1);
   endfunction

   // One LFSR step per bit taken
   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
   endtask

   // Bank 0, 1 or l_none; bit 5 inside a span is unmapped
   function automatic int decode_bank(input logic [`WB_IO_ADR_W-1:0] adr);
      if (adr[5]) begin
         return l_none;
      end
      if (adr[`WB_IO_ADR_W-1:6] == l_gpio_base[`WB_IO_ADR_W-1:6]) begin
         return 0;
      end
      if (adr[`WB_IO_ADR_W-1:6] == l_btn_base[`WB_IO_ADR_W-1:6]) begin
         return 1;
      end
      return l_none;
   endfunction

   function automatic logic [31:0] bank_mask(input int b);
      return (b == 1) ? {{(32 - `BTN_WIDTH){1'b0}}, {`BTN_WIDTH{1'b1}}} : {32{1'b1}};
   endfunction

   function automatic logic [31:0] model_read(input int b, input logic [2:0] ri);
      case (ri)
         3'd0:    return m_in[b];
         3'd1:    return m_out[b];
         3'd2:    return m_oe[b];
         3'd3:    return m_en[b];
         3'd4:    return m_st[b];
         default: return '0;
      endcase
   endfunction

   task automatic apply_write(input int b, input logic [2:0] ri, input logic [31:0] d,
                              input logic [3:0] sel);
      logic [31:0] lm;
      logic [31:0] bits;
      lm   = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}} & bank_mask(b);
      bits = d & lm;
      case (ri)
         3'd1:    m_out[b] = (m_out[b] & ~lm) | bits;
         3'd2:    m_oe[b]  = (m_oe[b] & ~lm) | bits;
         3'd3:    m_en[b]  = (m_en[b] & ~lm) | bits;
         3'd4:    m_st[b]  = m_st[b] & ~bits;
         default: ;
      endcase
   endtask

   task automatic next_slot();
      @(posedge clk);
      #l_drv_dly;
   endtask

   //**************************************************************************
   // Stimulus
   //**************************************************************************
   // New pins, wait out the synchronizer, then ask for a pin and irq check
   task automatic run_gap();
      logic [31:0] r;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      take_bits(`GPIO_WIDTH, r);
      gpio_in = r;
      m_st[0] = m_st[0] | (r & ~m_in[0]);
      m_in[0] = r;
      take_bits(`BTN_WIDTH, r);
      btn_in  = r[`BTN_WIDTH-1:0];
      m_st[1] = m_st[1] | (r & ~m_in[1]);
      m_in[1] = r;
      repeat (l_gap) next_slot();
      idle_chk    = 1'b1;
      exp_gpio    = m_out[0];
      exp_gpio_oe = m_oe[0];
      exp_btn     = m_out[1][`BTN_WIDTH-1:0];
      exp_btn_oe  = m_oe[1][`BTN_WIDTH-1:0];
      exp_irq     = (|(m_st[0] & m_en[0])) || (|(m_st[1] & m_en[1]));
   endtask

   task automatic run_batch(input int n);
      logic [31:0]             r;
      logic [`WB_IO_ADR_W-1:0] adr;
      int                      b;
      for (int i = 0; i < n; i++) begin
         take_bits(2, r);
         if (r[1:0] == 2'd3) begin
            take_bits(`WB_IO_ADR_W, r);
            adr = r[`WB_IO_ADR_W-1:0];
         end else begin
            adr = (r[1:0] == 2'd1) ? l_btn_base : l_gpio_base;
            take_bits(5, r);
            adr = adr | {11'd0, r[4:0]};
         end
         b = decode_bank(adr);
         take_bits(1, r);
         wb_we = r[0];
         take_bits(32, r);
         wb_dat = r;
         take_bits(4, r);
         wb_sel    = r[3:0];
         wb_adr    = adr;
         wb_cyc    = 1'b1;
         wb_stb    = 1'b1;
         exp_err   = (b == l_none);
         exp_rdata = '0;
         if (b != l_none) begin
            if (wb_we) begin
               apply_write(b, adr[4:2], wb_dat, wb_sel);
            end else begin
               exp_rdata = model_read(b, adr[4:2]);
            end
         end
         next_slot();
         idle_chk = 1'b0;
         // Random idle cycle, otherwise back to back
         take_bits(1, r);
         if (r[0]) begin
            wb_stb = 1'b0;
            next_slot();
         end
      end
      wb_stb = 1'b0;
   endtask

   initial begin
      rst         = 1'b1;
      wb_cyc      = 1'b0;
      wb_stb      = 1'b0;
      wb_we       = 1'b0;
      wb_adr      = '0;
      wb_dat      = '0;
      wb_sel      = '0;
      gpio_in     = '0;
      btn_in      = '0;
      exp_err     = 1'b0;
      exp_rdata   = '0;
      idle_chk    = 1'b0;
      exp_gpio    = '0;
      exp_gpio_oe = '0;
      exp_btn     = '0;
      exp_btn_oe  = '0;
      exp_irq     = 1'b0;
      lfsr        = 32'd95;
      for (int b = 0; b < 2; b++) begin
         m_in[b]  = '0;
         m_out[b] = '0;
         m_oe[b]  = '0;
         m_en[b]  = '0;
         m_st[b]  = '0;
      end
      repeat (l_rst_cycles) @(posedge clk);
      #l_drv_dly;
      rst = 1'b0;
      for (int g = 0; g < l_num_gaps; g++) begin
         run_gap();
         if (g < l_num_gaps - 1) begin
            run_batch(l_batch);
         end
      end
      next_slot();
      idle_chk = 1'b0;
      next_slot();
      $display("Checks %0d, value errors %0d, protocol errors %0d, responses pending %0d",
               chk_cnt, val_errs, proto_errs, pending);
      if (val_errs == 0 && proto_errs == 0 && pending == 0 && chk_cnt > 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

   // Watchdog
   initial begin
      #(l_max_cycles * l_clk_period);
      $display("Timeout: the run did not finish within %0d clock cycles", l_max_cycles);
      $display("ERRORS FOUND");
      $finish;
   end

endmodule

`default_nettype wire
